/* verilog/tracker_config.svh */
`ifndef TRACKER_CONFIG_SVH
`define TRACKER_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// colour classification, 4-bit channels
//////////////////////////////////////////////////////////////////////

// bright means strictly above this
`define TRK_BRIGHT_MIN 12
// dark means strictly below this
`define TRK_DARK_MAX 3

//////////////////////////////////////////////////////////////////////
// datapath widths and timing
//////////////////////////////////////////////////////////////////////

// screen coordinates, x < 320 and y < 240
`define TRK_X_W 9
`define TRK_Y_W 8
// per-frame pixel count and coordinate sums
`define TRK_COUNT_W 16
`define TRK_SUM_W 24
// sign-magnitude displacement
`define TRK_MAG_W 13
// frames per motion window
`define TRK_WINDOW 16
// one quotient bit per divider step
`define TRK_DIV_STEPS 24

`endif

/* verilog/tracker_pkg.sv */
`include "tracker_config.svh"

package tracker_pkg;

    //////////////////////////////////////////////////////////////////////
    // pixel input
    //////////////////////////////////////////////////////////////////////

    typedef logic [`TRK_X_W-1:0] coord_x_t;
    typedef logic [`TRK_Y_W-1:0] coord_y_t;

    // one decoded pixel, rgb is 4:4:4
    typedef struct packed {
        logic        valid;
        logic [11:0] rgb;
        coord_x_t    x;
        coord_y_t    y;
    } pixel_t;

    //////////////////////////////////////////////////////////////////////
    // per-frame statistics
    //////////////////////////////////////////////////////////////////////

    // one player's blob, 64 bits
    typedef struct packed {
        logic [`TRK_COUNT_W-1:0] count;
        logic [`TRK_SUM_W-1:0]   x_sum;
        logic [`TRK_SUM_W-1:0]   y_sum;
    } blob_sums_t;

    // both players plus end-of-window flag
    typedef struct packed {
        blob_sums_t p1;
        blob_sums_t p2;
        logic       window_end;
    } frame_stats_t;

    // found clear when the blob had no pixels
    typedef struct packed {
        logic     found;
        coord_x_t x;
        coord_y_t y;
    } centroid_t;

    //////////////////////////////////////////////////////////////////////
    // motion
    //////////////////////////////////////////////////////////////////////

    // neg set means moving toward lower coordinates
    typedef struct packed {
        logic                  neg;
        logic [`TRK_MAG_W-1:0] mag;
    } axis_motion_t;

    typedef struct packed {
        axis_motion_t dx;
        axis_motion_t dy;
    } motion_t;

endpackage

/* verilog/blob_accumulator.sv */
`timescale 1ns/1ps
`include "tracker_config.svh"

module blob_accumulator import tracker_pkg::*; (
    input  logic         clk_65mhz,
    input  logic         rst_n,
    input  pixel_t       pixel,
    input  logic         frame_done,
    output frame_stats_t stats,
    output logic         stats_strobe
);

    localparam int FRAME_W = $clog2(`TRK_WINDOW);

    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic is_p1;
    logic is_p2;
    blob_sums_t sums_p1;
    blob_sums_t sums_p2;
    logic [FRAME_W-1:0] frame_cnt;
    logic last_frame;

    //////////////////////////////////////////////////////////////////////
    // pixel classification
    //////////////////////////////////////////////////////////////////////

    assign red = pixel.rgb[11:8];
    assign green = pixel.rgb[7:4];
    assign blue = pixel.rgb[3:0];

    // strong red with almost no green or blue
    assign is_p1 = pixel.valid && (red > 4'(`TRK_BRIGHT_MIN))
        && (green < 4'(`TRK_DARK_MAX)) && (blue < 4'(`TRK_DARK_MAX));
    // white led has all three saturated
    assign is_p2 = pixel.valid && (red > 4'(`TRK_BRIGHT_MIN))
        && (green > 4'(`TRK_BRIGHT_MIN)) && (blue > 4'(`TRK_BRIGHT_MIN));

    // 16th frame of the window
    assign last_frame = (frame_cnt == FRAME_W'(`TRK_WINDOW - 1));

    //////////////////////////////////////////////////////////////////////
    // running sums and frame counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            sums_p1 <= '0;
            sums_p2 <= '0;
            frame_cnt <= '0;
            stats_strobe <= 1'b0;
        end else begin
            stats_strobe <= frame_done;
            if (frame_done) begin
                // never a valid pixel in this cycle, so just clear
                sums_p1 <= '0;
                sums_p2 <= '0;
                frame_cnt <= last_frame ? '0 : frame_cnt + 1'b1;
            end else if (is_p1) begin
                sums_p1.count <= sums_p1.count + 1'b1;
                sums_p1.x_sum <= sums_p1.x_sum
                    + {{(`TRK_SUM_W - `TRK_X_W){1'b0}}, pixel.x};
                sums_p1.y_sum <= sums_p1.y_sum
                    + {{(`TRK_SUM_W - `TRK_Y_W){1'b0}}, pixel.y};
            end else if (is_p2) begin
                sums_p2.count <= sums_p2.count + 1'b1;
                sums_p2.x_sum <= sums_p2.x_sum
                    + {{(`TRK_SUM_W - `TRK_X_W){1'b0}}, pixel.x};
                sums_p2.y_sum <= sums_p2.y_sum
                    + {{(`TRK_SUM_W - `TRK_Y_W){1'b0}}, pixel.y};
            end
        end
    end

    // frame summary, held until the next frame_done
    always_ff @(posedge clk_65mhz) begin
        if (frame_done) begin
            stats.p1 <= sums_p1;
            stats.p2 <= sums_p2;
            stats.window_end <= last_frame;
        end
    end

endmodule

/* verilog/centroid_divider.sv */
`timescale 1ns/1ps
`include "tracker_config.svh"

module centroid_divider import tracker_pkg::*; (
    input  logic       clk_65mhz,
    input  logic       rst_n,
    input  blob_sums_t sums,
    input  logic       window_end,
    input  logic       start,
    output centroid_t  centroid,
    output logic       window_end_out,
    output logic       centroid_strobe
);

    // partial remainder needs one bit over the divisor
    localparam int REM_W = `TRK_COUNT_W + 1;
    localparam int STEP_W = $clog2(`TRK_DIV_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`TRK_DIV_STEPS - 1);

    logic busy;
    logic [STEP_W-1:0] step_cnt;
    logic [`TRK_COUNT_W-1:0] divisor;
    logic window_end_hold;
    logic [REM_W-1:0] x_rem;
    logic [REM_W-1:0] y_rem;
    // dividend shifts out the top, quotient shifts in the bottom
    logic [`TRK_SUM_W-1:0] x_quo;
    logic [`TRK_SUM_W-1:0] y_quo;
    logic [REM_W-1:0] x_rem_next;
    logic [REM_W-1:0] y_rem_next;
    logic [`TRK_SUM_W-1:0] x_quo_next;
    logic [`TRK_SUM_W-1:0] y_quo_next;

    //////////////////////////////////////////////////////////////////////
    // one restoring step
    //////////////////////////////////////////////////////////////////////

    function automatic logic [REM_W+`TRK_SUM_W-1:0] div_step(
        input logic [REM_W-1:0]        rem,
        input logic [`TRK_SUM_W-1:0]   quo,
        input logic [`TRK_COUNT_W-1:0] den
    );
        logic [REM_W-1:0] trial;
        trial = {rem[REM_W-2:0], quo[`TRK_SUM_W-1]};
        // subtract only when it fits, else restore
        if (trial >= {1'b0, den}) begin
            div_step = {trial - {1'b0, den}, quo[`TRK_SUM_W-2:0], 1'b1};
        end else begin
            div_step = {trial, quo[`TRK_SUM_W-2:0], 1'b0};
        end
    endfunction

    // x and y share the divisor
    assign {x_rem_next, x_quo_next} = div_step(x_rem, x_quo, divisor);
    assign {y_rem_next, y_quo_next} = div_step(y_rem, y_quo, divisor);

    //////////////////////////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz) begin
        if (start) begin
            x_rem <= '0;
            y_rem <= '0;
            x_quo <= sums.x_sum;
            y_quo <= sums.y_sum;
            divisor <= sums.count;
            window_end_hold <= window_end;
        end else if (busy) begin
            x_rem <= x_rem_next;
            y_rem <= y_rem_next;
            x_quo <= x_quo_next;
            y_quo <= y_quo_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // step control and result
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step_cnt <= '0;
            centroid <= '0;
            window_end_out <= 1'b0;
            centroid_strobe <= 1'b0;
        end else begin
            centroid_strobe <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (step_cnt == LAST_STEP) begin
                    // last step result goes straight to the output
                    busy <= 1'b0;
                    centroid_strobe <= 1'b1;
                    window_end_out <= window_end_hold;
                    centroid.found <= (divisor != '0);
                    // empty blob keeps the last position
                    if (divisor != '0) begin
                        centroid.x <= x_quo_next[`TRK_X_W-1:0];
                        centroid.y <= y_quo_next[`TRK_Y_W-1:0];
                    end
                end
            end
        end
    end

endmodule

/* verilog/motion_accumulator.sv */
`timescale 1ns/1ps
`include "tracker_config.svh"

module motion_accumulator import tracker_pkg::*; #(
    parameter type coord_t = coord_x_t
) (
    input  logic         clk_65mhz,
    input  logic         rst_n,
    input  coord_t       coord,
    input  logic         found,
    input  logic         update,
    input  logic         window_end,
    output axis_motion_t motion,
    output logic         motion_strobe
);

    localparam int CW = $bits(coord_t);

    coord_t prev;
    logic have_prev;
    logic [CW-1:0] diff_mag;
    logic diff_neg;
    axis_motion_t step_delta;
    axis_motion_t total;
    axis_motion_t total_next;

    //////////////////////////////////////////////////////////////////////
    // frame to frame delta, sign-magnitude
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        diff_neg = (coord < prev);
        diff_mag = diff_neg ? prev - coord : coord - prev;
        step_delta.neg = diff_neg;
        step_delta.mag = {{(`TRK_MAG_W - CW){1'b0}}, diff_mag};
    end

    // add delta into the window total
    always_comb begin
        total_next = total;
        if (found && have_prev) begin
            if (step_delta.neg == total.neg) begin
                total_next.mag = total.mag + step_delta.mag;
            end else if (total.mag >= step_delta.mag) begin
                total_next.mag = total.mag - step_delta.mag;
            end else begin
                // delta wins, sign flips
                total_next.neg = step_delta.neg;
                total_next.mag = step_delta.mag - total.mag;
            end
            // zero is always positive
            if (total_next.mag == '0) begin
                total_next.neg = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // window total and output
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_65mhz or negedge rst_n) begin
        if (!rst_n) begin
            have_prev <= 1'b0;
            total <= '0;
            motion <= '0;
            motion_strobe <= 1'b0;
        end else begin
            motion_strobe <= 1'b0;
            if (update) begin
                // first found centroid only seeds prev
                if (found) begin
                    have_prev <= 1'b1;
                end
                if (window_end) begin
                    motion <= total_next;
                    motion_strobe <= 1'b1;
                    total <= '0;
                end else begin
                    total <= total_next;
                end
            end
        end
    end

    // last found position
    always_ff @(posedge clk_65mhz) begin
        if (update && found) begin
            prev <= coord;
        end
    end

endmodule

/* verilog/led_tracker_top.sv */
`timescale 1ns/1ps

module led_tracker_top import tracker_pkg::*; (
    input  logic      clk_65mhz,
    input  logic      rst_n,
    input  pixel_t    pixel,
    input  logic      frame_done,
    output centroid_t centroid_p1,
    output centroid_t centroid_p2,
    output logic      centroid_p1_strobe,
    output logic      centroid_p2_strobe,
    output motion_t   motion_p1,
    output motion_t   motion_p2,
    output logic      motion_p1_strobe,
    output logic      motion_p2_strobe
);

    frame_stats_t stats;
    logic stats_strobe;
    logic window_end_p1;
    logic window_end_p2;
    // x and y of one player always fire together
    logic strobe_p1_x;
    logic strobe_p1_y;
    logic strobe_p2_x;
    logic strobe_p2_y;

    assign motion_p1_strobe = strobe_p1_x & strobe_p1_y;
    assign motion_p2_strobe = strobe_p2_x & strobe_p2_y;

    //////////////////////////////////////////////////////////////////////
    // per-frame sums and centroids
    //////////////////////////////////////////////////////////////////////

    blob_accumulator blob_accumulator_inst (
        .clk_65mhz    (clk_65mhz),
        .rst_n        (rst_n),
        .pixel        (pixel),
        .frame_done   (frame_done),
        .stats        (stats),
        .stats_strobe (stats_strobe)
    );

    // red led
    centroid_divider centroid_divider_p1_inst (
        .clk_65mhz       (clk_65mhz),
        .rst_n           (rst_n),
        .sums            (stats.p1),
        .window_end      (stats.window_end),
        .start           (stats_strobe),
        .centroid        (centroid_p1),
        .window_end_out  (window_end_p1),
        .centroid_strobe (centroid_p1_strobe)
    );

    // white led
    centroid_divider centroid_divider_p2_inst (
        .clk_65mhz       (clk_65mhz),
        .rst_n           (rst_n),
        .sums            (stats.p2),
        .window_end      (stats.window_end),
        .start           (stats_strobe),
        .centroid        (centroid_p2),
        .window_end_out  (window_end_p2),
        .centroid_strobe (centroid_p2_strobe)
    );

    //////////////////////////////////////////////////////////////////////
    // window motion, one accumulator per axis per player
    //////////////////////////////////////////////////////////////////////

    motion_accumulator #(.coord_t(coord_x_t)) motion_p1_x_inst (
        .clk_65mhz     (clk_65mhz),
        .rst_n         (rst_n),
        .coord         (centroid_p1.x),
        .found         (centroid_p1.found),
        .update        (centroid_p1_strobe),
        .window_end    (window_end_p1),
        .motion        (motion_p1.dx),
        .motion_strobe (strobe_p1_x)
    );

    motion_accumulator #(.coord_t(coord_y_t)) motion_p1_y_inst (
        .clk_65mhz     (clk_65mhz),
        .rst_n         (rst_n),
        .coord         (centroid_p1.y),
        .found         (centroid_p1.found),
        .update        (centroid_p1_strobe),
        .window_end    (window_end_p1),
        .motion        (motion_p1.dy),
        .motion_strobe (strobe_p1_y)
    );

    motion_accumulator #(.coord_t(coord_x_t)) motion_p2_x_inst (
        .clk_65mhz     (clk_65mhz),
        .rst_n         (rst_n),
        .coord         (centroid_p2.x),
        .found         (centroid_p2.found),
        .update        (centroid_p2_strobe),
        .window_end    (window_end_p2),
        .motion        (motion_p2.dx),
        .motion_strobe (strobe_p2_x)
    );

    motion_accumulator #(.coord_t(coord_y_t)) motion_p2_y_inst (
        .clk_65mhz     (clk_65mhz),
        .rst_n         (rst_n),
        .coord         (centroid_p2.y),
        .found         (centroid_p2.found),
        .update        (centroid_p2_strobe),
        .window_end    (window_end_p2),
        .motion        (motion_p2.dy),
        .motion_strobe (strobe_p2_y)
    );

endmodule

/* testbench/led_tracker_tb.sv */
`timescale 1ns/1ps
`include "tracker_config.svh"

module led_tracker_tb import tracker_pkg::*; ();

    localparam int NUM_FRAMES = 2 * `TRK_WINDOW;
    localparam int PIXELS_PER_FRAME = 24;
    // frame with the red led hidden
    localparam int NO_P1_FRAME = 2;
    // counted from the cycle that carries frame_done
    localparam int CENTROID_DELAY = 26;
    localparam int MOTION_DELAY = 27;
    localparam int WAIT_LIMIT = 500;

    logic clk_65mhz = 1'b0;
    logic rst_n;
    pixel_t pixel;
    logic frame_done;
    centroid_t centroid_p1;
    centroid_t centroid_p2;
    logic centroid_p1_strobe;
    logic centroid_p2_strobe;
    motion_t motion_p1;
    motion_t motion_p2;
    logic motion_p1_strobe;
    logic motion_p2_strobe;

    logic [31:0] lfsr_state = 32'h6b60_fe2c;
    int error_count = 0;
    int check_count = 0;
    int frames_checked = 0;

    // expected results, one entry per frame
    centroid_t exp_c1_q[$];
    centroid_t exp_c2_q[$];
    logic exp_we_q[$];
    motion_t exp_m1_q[$];
    motion_t exp_m2_q[$];

    // reference model state with p1 at index 0
    centroid_t last_c[2] = '{default: '0};
    logic have_prev[2] = '{default: 1'b0};
    int prev_x[2] = '{default: 0};
    int prev_y[2] = '{default: 0};
    int tot_x[2] = '{default: 0};
    int tot_y[2] = '{default: 0};

    led_tracker_top led_tracker_top_inst (
        .clk_65mhz          (clk_65mhz),
        .rst_n              (rst_n),
        .pixel              (pixel),
        .frame_done         (frame_done),
        .centroid_p1        (centroid_p1),
        .centroid_p2        (centroid_p2),
        .centroid_p1_strobe (centroid_p1_strobe),
        .centroid_p2_strobe (centroid_p2_strobe),
        .motion_p1          (motion_p1),
        .motion_p2          (motion_p2),
        .motion_p1_strobe   (motion_p1_strobe),
        .motion_p2_strobe   (motion_p2_strobe)
    );

    // 50 MHz stand-in for the pixel clock
    always #10 clk_65mhz = ~clk_65mhz;

    //////////////////////////////////////////////////////////////////////
    // random source with taps x^32 + x^22 + x^2 + x + 1
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    // first bit ends up msb
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [3:0] bright_nibble();
        logic [31:0] r;
        r = random_bits(2);
        return 4'(`TRK_BRIGHT_MIN + 1 + r % 3);
    endfunction

    function automatic logic [3:0] dark_nibble();
        logic [31:0] r;
        r = random_bits(2);
        return 4'(r % `TRK_DARK_MAX);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // 0 none, 1 red led, 2 white led
    function automatic int classify(input pixel_t p);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = p.rgb[11:8];
        g = p.rgb[7:4];
        b = p.rgb[3:0];
        if (!p.valid) return 0;
        if (r > `TRK_BRIGHT_MIN && g < `TRK_DARK_MAX && b < `TRK_DARK_MAX) return 1;
        if (r > `TRK_BRIGHT_MIN && g > `TRK_BRIGHT_MIN && b > `TRK_BRIGHT_MIN) return 2;
        return 0;
    endfunction

    // floor of sum over count
    // empty blob keeps the old spot
    function automatic centroid_t expected_centroid(input int count, input int x_sum,
                                                    input int y_sum, input centroid_t last);
        centroid_t c;
        c = last;
        c.found = (count != 0);
        if (count != 0) begin
            c.x = coord_x_t'(x_sum / count);
            c.y = coord_y_t'(y_sum / count);
        end
        return c;
    endfunction

    function automatic axis_motion_t sign_magnitude(input int v);
        axis_motion_t m;
        int a;
        a = (v < 0) ? -v : v;
        m.neg = (v < 0);
        m.mag = a[`TRK_MAG_W-1:0];
        return m;
    endfunction

    // first found centroid only seeds the previous position
    function automatic void accumulate_motion(input int p, input centroid_t c);
        if (c.found && have_prev[p]) begin
            tot_x[p] += int'(c.x) - prev_x[p];
            tot_y[p] += int'(c.y) - prev_y[p];
        end
        if (c.found) begin
            have_prev[p] = 1'b1;
            prev_x[p] = int'(c.x);
            prev_y[p] = int'(c.y);
        end
    endfunction

    // red moves right 8 frames, then left past its start
    function automatic int p1_center_x(input int f);
        int k;
        k = f % `TRK_WINDOW;
        if (k < 8) return 100 + 6 * k;
        return 142 - 10 * (k - 7);
    endfunction

    // white only climbs in y
    function automatic int p2_center_y(input int f);
        return 60 + 7 * (f % `TRK_WINDOW);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("ERROR: %s", what);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic expect_strobe(input string what, input logic actual, input logic expected);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("%s %s", what, expected ? "did not pulse" : "pulsed unexpectedly");
        end
    endtask

    task automatic check_strobes(input string when, input logic c_exp, input logic m_exp);
        expect_strobe({"centroid_p1_strobe ", when}, centroid_p1_strobe, c_exp);
        expect_strobe({"centroid_p2_strobe ", when}, centroid_p2_strobe, c_exp);
        expect_strobe({"motion_p1_strobe ", when}, motion_p1_strobe, m_exp);
        expect_strobe({"motion_p2_strobe ", when}, motion_p2_strobe, m_exp);
    endtask

    // outputs sampled on the falling edge, away from the updates
    task automatic check_frame(input int f, output logic arrived);
        int waited;
        centroid_t exp_c1;
        centroid_t exp_c2;
        logic exp_we;
        motion_t exp_m1;
        motion_t exp_m2;
        waited = 0;
        // quiet until frame_done
        while (frame_done !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk_65mhz);
            waited++;
            check_strobes($sformatf("before frame_done %0d", f), 1'b0, 1'b0);
        end
        arrived = (frame_done === 1'b1);
        assert (arrived) else begin
            report_failure($sformatf("frame_done %0d never arrived", f));
        end
        if (!arrived) begin
            return;
        end
        exp_c1 = exp_c1_q.pop_front();
        exp_c2 = exp_c2_q.pop_front();
        exp_we = exp_we_q.pop_front();
        exp_m1 = exp_m1_q.pop_front();
        exp_m2 = exp_m2_q.pop_front();
        for (int n = 1; n <= MOTION_DELAY; n++) begin
            @(negedge clk_65mhz);
            check_strobes($sformatf("%0d cycles after frame_done %0d", n, f),
                          n == CENTROID_DELAY, n == MOTION_DELAY && exp_we);
            if (n == CENTROID_DELAY) begin
                check_value($sformatf("centroid_p1 frame %0d", f), 64'(exp_c1), 64'(centroid_p1));
                check_value($sformatf("centroid_p2 frame %0d", f), 64'(exp_c2), 64'(centroid_p2));
            end
            if (n == MOTION_DELAY && exp_we) begin
                check_value($sformatf("motion_p1 frame %0d", f), 64'(exp_m1), 64'(motion_p1));
                check_value($sformatf("motion_p2 frame %0d", f), 64'(exp_m2), 64'(motion_p2));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(input pixel_t p, input logic fd);
        @(posedge clk_65mhz);
        #2;
        pixel = p;
        frame_done = fd;
    endtask

    task automatic send_frame(input int f);
        pixel_t p;
        int cls;
        int cnt[3];
        int xs[3];
        int ys[3];
        centroid_t c1;
        centroid_t c2;
        motion_t m1;
        motion_t m2;
        logic last_frame;
        cnt = '{default: 0};
        xs = '{default: 0};
        ys = '{default: 0};
        for (int i = 0; i < PIXELS_PER_FRAME; i++) begin
            p = '0;
            if (i % 4 == 0 && f != NO_P1_FRAME) begin
                // red led with jitter only on x
                p.valid = 1'b1;
                p.rgb = {bright_nibble(), dark_nibble(), dark_nibble()};
                p.x = coord_x_t'(p1_center_x(f) + random_bits(3));
                p.y = coord_y_t'(120 + (i / 4) % 4);
            end else if (i % 4 == 1) begin
                // white led is bright in red too
                p.valid = 1'b1;
                p.rgb = {bright_nibble(), bright_nibble(), bright_nibble()};
                p.x = coord_x_t'(220 + (i / 4) % 3);
                p.y = coord_y_t'(p2_center_y(f) + random_bits(3));
            end else if (i % 8 == 3) begin
                // red colour but not valid
                p.rgb = 12'hf00;
                p.x = coord_x_t'(p1_center_x(f));
                p.y = coord_y_t'(40);
            end else begin
                // blue held at 4..7 so neither led matches
                p.valid = 1'b1;
                p.rgb = 12'(random_bits(12));
                p.rgb[3:2] = 2'b01;
                p.x = coord_x_t'(random_bits(9) % 320);
                p.y = coord_y_t'(random_bits(8) % 240);
            end
            cls = classify(p);
            cnt[cls]++;
            xs[cls] += int'(p.x);
            ys[cls] += int'(p.y);
            drive_cycle(p, 1'b0);
        end
        c1 = expected_centroid(cnt[1], xs[1], ys[1], last_c[0]);
        c2 = expected_centroid(cnt[2], xs[2], ys[2], last_c[1]);
        last_c[0] = c1;
        last_c[1] = c2;
        accumulate_motion(0, c1);
        accumulate_motion(1, c2);
        last_frame = ((f % `TRK_WINDOW) == (`TRK_WINDOW - 1));
        m1 = '0;
        m2 = '0;
        // window total published, then restart from zero
        if (last_frame) begin
            m1 = {sign_magnitude(tot_x[0]), sign_magnitude(tot_y[0])};
            m2 = {sign_magnitude(tot_x[1]), sign_magnitude(tot_y[1])};
            tot_x = '{default: 0};
            tot_y = '{default: 0};
        end
        exp_c1_q.push_back(c1);
        exp_c2_q.push_back(c2);
        exp_we_q.push_back(last_frame);
        exp_m1_q.push_back(m1);
        exp_m2_q.push_back(m2);
        drive_cycle('0, 1'b1);
        drive_cycle('0, 1'b0);
    endtask

    initial begin : stimulus
        int waited;
        logic stalled;
        rst_n = 1'b0;
        frame_done = 1'b0;
        pixel = '0;
        stalled = 1'b0;
        repeat (4) @(posedge clk_65mhz);
        #2;
        rst_n = 1'b1;
        for (int f = 0; f < NUM_FRAMES && !stalled; f++) begin
            send_frame(f);
            // next frame only once this one is checked
            waited = 0;
            while (frames_checked <= f && waited < WAIT_LIMIT) begin
                @(negedge clk_65mhz);
                waited++;
            end
            stalled = (frames_checked <= f);
            assert (!stalled) else begin
                report_failure($sformatf("checker did not finish frame %0d in time", f));
            end
        end
        finish_run();
    end

    initial begin : compare
        logic arrived;
        arrived = 1'b1;
        for (int f = 0; f < NUM_FRAMES && arrived; f++) begin
            check_frame(f, arrived);
            if (arrived) begin
                frames_checked++;
            end
        end
        // stimulus stopped sending frames
        if (!arrived) begin
            finish_run();
        end
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/tracker_pkg.sv
verilog/blob_accumulator.sv
verilog/centroid_divider.sv
verilog/motion_accumulator.sv
verilog/led_tracker_top.sv
testbench/led_tracker_tb.sv

/* Makefile */
TOP = led_tracker_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
